//--- Makefile
# Verilator lint, simulation and clean for the mesh node

TOP := tb_mesh_node

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level
lint:
	verilator --lint-only --timing -f tb.f --top-module mesh_node

# Build and run the testbench, pass only if the log holds the pass line
sim:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/mesh_defines.svh
// Mesh coordinate, store and message width macros

`ifndef MESH_DEFINES_SVH
`define MESH_DEFINES_SVH

// Coordinate width for a row or a column
`define MESH_COORD_W 4

// Data store geometry
`define MESH_ADDR_W 6
`define MESH_DATA_W 16

// Raw message width on every link
`define MESH_MSG_W 32

`endif

//--- design/mesh_node.sv
// mesh_node: node top level with arbitration, local decode, routing and idle chaining
`timescale 1ns/1ps
`default_nettype none

`include "mesh_defines.svh"

module mesh_node #(
      parameter mesh_pkg::arb_scheme_t INBOUND_SCHEME = mesh_pkg::ARB_ROUND_ROBIN
) (
      input  wire logic                        i_clk
    , input  wire logic                        i_rst
    // Identity and idle chain
    , input  wire mesh_pkg::node_id_t          i_node_id
    , input  wire logic                        i_idle
    , output logic                             o_idle
    // Inbound streams
    , input  wire logic [3:0][`MESH_MSG_W-1:0] i_inbound_data
    , input  wire logic [3:0]                  i_inbound_valid
    , output logic [3:0]                       o_inbound_ready
    // Outbound streams
    , output logic [3:0][`MESH_MSG_W-1:0]      o_outbound_data
    , output logic [3:0]                       o_outbound_valid
    , input  wire logic [3:0]                  i_outbound_ready
    , input  wire logic [3:0]                  i_outbound_present
);

import mesh_pkg::*;

// ========================================
// Signals
// ========================================

// Per-block idle flags
struct packed { logic decode, respond, distrib; } comp_idle;
logic idle_q;

// Inbound arbiter
node_message_t arb_data;
logic          arb_valid, arb_ready, arb_match;

// Combiner, port 0 bypass and port 1 responses
node_message_t [1:0] comb_data;
logic [1:0]          comb_valid, comb_ready;

// Routed stream into the distributor
node_message_t outbound_data;
logic          outbound_valid, outbound_ready;
direction_t    outbound_dir;

// Decoder to store and responder
logic                    dcd_valid, dcd_ready;
logic [`MESH_ADDR_W-1:0] dcd_wr_addr;
logic [`MESH_DATA_W-1:0] dcd_wr_data;
logic                    dcd_wr_en;
logic [`MESH_ADDR_W-1:0] req_addr;
node_id_t                req_return;
logic                    req_valid, req_ready;

// Responder read port
logic [`MESH_ADDR_W-1:0] rsp_rd_addr;
logic [`MESH_DATA_W-1:0] rsp_rd_data;
logic                    rsp_rd_en;

// ========================================
// Idle chaining
// ========================================

always_ff @(posedge i_clk) begin : ff_idle
    if (i_rst) begin
        idle_q <= 1'b1;
    end else begin
        idle_q <= (&comp_idle) && !arb_valid && !(|comb_valid) && !outbound_valid;
    end
end

assign o_idle = idle_q && i_idle;

// ========================================
// Inbound arbitration and address match
// ========================================

mesh_stream_arbiter #(
      .STREAMS          ( 4               )
    , .SCHEME           ( INBOUND_SCHEME  )
) u_arbiter (
      .i_clk            ( i_clk           )
    , .i_rst            ( i_rst           )
    , .i_inbound_data   ( i_inbound_data  )
    , .i_inbound_valid  ( i_inbound_valid )
    , .o_inbound_ready  ( o_inbound_ready )
    , .o_outbound_data  ( arb_data        )
    , .o_outbound_valid ( arb_valid       )
    , .i_outbound_ready ( arb_ready       )
);

// Own row and column means local decode
assign arb_match = (arb_data.header.row    == i_node_id.row) &&
                   (arb_data.header.column == i_node_id.column);

assign dcd_valid     = arb_valid &&  arb_match;
assign comb_valid[0] = arb_valid && !arb_match;
assign comb_data[0]  = arb_data;

// Ready from whichever path the message takes
assign arb_ready = arb_match ? dcd_ready : comb_ready[0];

// ========================================
// Combiner
// ========================================

// Bypass traffic wins over responses
mesh_stream_arbiter #(
      .STREAMS          ( 2              )
    , .SCHEME           ( ARB_ORDINAL    )
) u_combiner (
      .i_clk            ( i_clk          )
    , .i_rst            ( i_rst          )
    , .i_inbound_data   ( comb_data      )
    , .i_inbound_valid  ( comb_valid     )
    , .o_inbound_ready  ( comb_ready     )
    , .o_outbound_data  ( outbound_data  )
    , .o_outbound_valid ( outbound_valid )
    , .i_outbound_ready ( outbound_ready )
);

// ========================================
// Routing and distribution
// ========================================

// Row first, then column, with clockwise fallback when a neighbour is absent
always_comb begin : comb_route
    logic lt_row, gt_row, lt_col, gt_col;
    lt_row = (outbound_data.header.row    < i_node_id.row);
    gt_row = (outbound_data.header.row    > i_node_id.row);
    lt_col = (outbound_data.header.column < i_node_id.column);
    gt_col = (outbound_data.header.column > i_node_id.column);
    casez ({ lt_row, gt_row, lt_col, gt_col })
        4'b1???: outbound_dir = i_outbound_present[DIRECTION_NORTH] ?
                                DIRECTION_NORTH : DIRECTION_EAST;
        4'b01??: outbound_dir = i_outbound_present[DIRECTION_SOUTH] ?
                                DIRECTION_SOUTH : DIRECTION_WEST;
        4'b0010: outbound_dir = i_outbound_present[DIRECTION_WEST] ?
                                DIRECTION_WEST : DIRECTION_NORTH;
        4'b0001: outbound_dir = i_outbound_present[DIRECTION_EAST] ?
                                DIRECTION_EAST : DIRECTION_SOUTH;
        // Self-addressed, no better choice
        default: outbound_dir = DIRECTION_NORTH;
    endcase
end

mesh_stream_distributor u_distributor (
      .i_clk            ( i_clk             )
    , .i_rst            ( i_rst             )
    , .o_idle           ( comp_idle.distrib )
    , .i_inbound_dir    ( outbound_dir      )
    , .i_inbound_data   ( outbound_data     )
    , .i_inbound_valid  ( outbound_valid    )
    , .o_inbound_ready  ( outbound_ready    )
    , .o_outbound_data  ( o_outbound_data   )
    , .o_outbound_valid ( o_outbound_valid  )
    , .i_outbound_ready ( i_outbound_ready  )
);

// ========================================
// Local decode, store and responder
// ========================================

mesh_node_decoder u_decoder (
      .i_clk         ( i_clk            )
    , .i_rst         ( i_rst            )
    , .o_idle        ( comp_idle.decode )
    , .i_msg_data    ( arb_data         )
    , .i_msg_valid   ( dcd_valid        )
    , .o_msg_ready   ( dcd_ready        )
    , .o_ram_addr    ( dcd_wr_addr      )
    , .o_ram_wr_data ( dcd_wr_data      )
    , .o_ram_wr_en   ( dcd_wr_en        )
    , .o_req_addr    ( req_addr         )
    , .o_req_return  ( req_return       )
    , .o_req_valid   ( req_valid        )
    , .i_req_ready   ( req_ready        )
);

mesh_node_store u_store (
      .i_clk     ( i_clk       )
    , .i_wr_addr ( dcd_wr_addr )
    , .i_wr_data ( dcd_wr_data )
    , .i_wr_en   ( dcd_wr_en   )
    , .i_rd_addr ( rsp_rd_addr )
    , .i_rd_en   ( rsp_rd_en   )
    , .o_rd_data ( rsp_rd_data )
);

mesh_node_responder u_responder (
      .i_clk         ( i_clk             )
    , .i_rst         ( i_rst             )
    , .o_idle        ( comp_idle.respond )
    , .i_req_addr    ( req_addr          )
    , .i_req_return  ( req_return        )
    , .i_req_valid   ( req_valid         )
    , .o_req_ready   ( req_ready         )
    , .o_ram_addr    ( rsp_rd_addr       )
    , .o_ram_rd_en   ( rsp_rd_en         )
    , .i_ram_rd_data ( rsp_rd_data       )
    , .o_msg_data    ( comb_data[1]      )
    , .o_msg_valid   ( comb_valid[1]     )
    , .i_msg_ready   ( comb_ready[1]     )
);

endmodule : mesh_node

`default_nettype wire

//--- design/mesh_node_decoder.sv
// mesh_node_decoder: local message decode, LOAD writes and READ request slot
`timescale 1ns/1ps
`default_nettype none

`include "mesh_defines.svh"

module mesh_node_decoder (
      input  wire logic                    i_clk
    , input  wire logic                    i_rst
    // Idle flag
    , output logic                         o_idle
    // Inbound messages for this node
    , input  wire mesh_pkg::node_message_t i_msg_data
    , input  wire logic                    i_msg_valid
    , output logic                         o_msg_ready
    // Store write port
    , output logic [`MESH_ADDR_W-1:0]      o_ram_addr
    , output logic [`MESH_DATA_W-1:0]      o_ram_wr_data
    , output logic                         o_ram_wr_en
    // Read requests toward the responder
    , output logic [`MESH_ADDR_W-1:0]      o_req_addr
    , output mesh_pkg::node_id_t           o_req_return
    , output logic                         o_req_valid
    , input  wire logic                    i_req_ready
);

import mesh_pkg::*;

logic accept;
logic is_load;
logic is_read;

// Stall while the request slot is full and not draining
assign o_msg_ready = !o_req_valid || i_req_ready;
assign accept      = i_msg_valid && o_msg_ready;

// Command decode, RESPONSE is simply dropped
assign is_load = (i_msg_data.header.command == MESH_CMD_LOAD);
assign is_read = (i_msg_data.header.command == MESH_CMD_READ);

assign o_idle = !o_req_valid && !o_ram_wr_en;

always_ff @(posedge i_clk) begin : ff_ctrl
    if (i_rst) begin
        o_ram_wr_en <= 1'b0;
        o_req_valid <= 1'b0;
    end else begin
        // Single-cycle write pulse
        o_ram_wr_en <= accept && is_load;
        if (accept && is_read) begin
            o_req_valid <= 1'b1;
        end else if (i_req_ready) begin
            o_req_valid <= 1'b0;
        end
    end
end

always_ff @(posedge i_clk) begin : ff_data
    if (accept && is_load) begin
        o_ram_addr    <= i_msg_data.addr;
        o_ram_wr_data <= i_msg_data.data;
    end
    // Return node sits in the low data bits
    if (accept && is_read) begin
        o_req_addr   <= i_msg_data.addr;
        o_req_return <= node_id_t'(i_msg_data.data[$bits(node_id_t)-1:0]);
    end
end

endmodule : mesh_node_decoder

`default_nettype wire

//--- design/mesh_node_responder.sv
// mesh_node_responder: READ request to RESPONSE message FSM
`timescale 1ns/1ps
`default_nettype none

`include "mesh_defines.svh"

module mesh_node_responder (
      input  wire logic                     i_clk
    , input  wire logic                     i_rst
    // Idle flag
    , output logic                          o_idle
    // Request stream from the decoder
    , input  wire logic [`MESH_ADDR_W-1:0]  i_req_addr
    , input  wire mesh_pkg::node_id_t       i_req_return
    , input  wire logic                     i_req_valid
    , output logic                          o_req_ready
    // Store read port
    , output logic [`MESH_ADDR_W-1:0]       o_ram_addr
    , output logic                          o_ram_rd_en
    , input  wire logic [`MESH_DATA_W-1:0]  i_ram_rd_data
    // Response stream into the combiner
    , output mesh_pkg::node_message_t       o_msg_data
    , output logic                          o_msg_valid
    , input  wire logic                     i_msg_ready
);

import mesh_pkg::*;

typedef enum logic [1:0] {
    RSP_IDLE,
    RSP_READ,
    RSP_SEND
} rsp_state_t;

rsp_state_t              state_q;
logic [`MESH_ADDR_W-1:0] addr_q;
node_id_t                return_q;
node_message_t           msg_q;
logic                    msg_valid_q;

// One request in flight
assign o_req_ready = (state_q == RSP_IDLE);
assign o_idle      = (state_q == RSP_IDLE);

// Read issued from the captured address
assign o_ram_addr  = addr_q;
assign o_ram_rd_en = (state_q == RSP_READ);

assign o_msg_data  = msg_q;
assign o_msg_valid = msg_valid_q;

always_ff @(posedge i_clk) begin : ff_fsm
    if (i_rst) begin
        state_q     <= RSP_IDLE;
        msg_valid_q <= 1'b0;
    end else begin
        case (state_q)
            RSP_IDLE: begin
                if (i_req_valid) begin
                    state_q <= RSP_READ;
                end
            end
            RSP_READ: state_q <= RSP_SEND;
            RSP_SEND: begin
                // First SEND cycle builds the response, then wait for the combiner
                if (!msg_valid_q) begin
                    msg_valid_q <= 1'b1;
                end else if (i_msg_ready) begin
                    msg_valid_q <= 1'b0;
                    state_q     <= RSP_IDLE;
                end
            end
            default: state_q <= RSP_IDLE;
        endcase
    end
end

always_ff @(posedge i_clk) begin : ff_data
    if (o_req_ready && i_req_valid) begin
        addr_q   <= i_req_addr;
        return_q <= i_req_return;
    end
    // Target is the requester
    if ((state_q == RSP_SEND) && !msg_valid_q) begin
        msg_q.header.row     <= return_q.row;
        msg_q.header.column  <= return_q.column;
        msg_q.header.command <= MESH_CMD_RESPONSE;
        msg_q.addr           <= addr_q;
        msg_q.data           <= i_ram_rd_data;
    end
end

endmodule : mesh_node_responder

`default_nettype wire

//--- design/mesh_node_store.sv
// mesh_node_store: single-write single-read data memory with registered read
`timescale 1ns/1ps
`default_nettype none

`include "mesh_defines.svh"

module mesh_node_store (
      input  wire logic                   i_clk
    // Write port
    , input  wire logic [`MESH_ADDR_W-1:0] i_wr_addr
    , input  wire logic [`MESH_DATA_W-1:0] i_wr_data
    , input  wire logic                   i_wr_en
    // Read port
    , input  wire logic [`MESH_ADDR_W-1:0] i_rd_addr
    , input  wire logic                   i_rd_en
    , output logic [`MESH_DATA_W-1:0]      o_rd_data
);

// Storage array
logic [`MESH_DATA_W-1:0] mem [2**`MESH_ADDR_W];

// Same-address collision reads the old word
always_ff @(posedge i_clk) begin : ff_mem
    if (i_wr_en) begin
        mem[i_wr_addr] <= i_wr_data;
    end
    if (i_rd_en) begin
        o_rd_data <= mem[i_rd_addr];
    end
end

endmodule : mesh_node_store

`default_nettype wire

//--- design/mesh_pkg.sv
// Mesh package: node id, command, header, message, direction and arbiter scheme types
`default_nettype none

`include "mesh_defines.svh"

package mesh_pkg;

// Node identity within the grid
typedef struct packed {
    logic [`MESH_COORD_W-1:0] row;
    logic [`MESH_COORD_W-1:0] column;
} node_id_t;

// Message commands
typedef enum logic [1:0] {
    MESH_CMD_LOAD     = 2'd0,
    MESH_CMD_READ     = 2'd1,
    MESH_CMD_RESPONSE = 2'd2
} mesh_cmd_t;

// Routing header, target first
typedef struct packed {
    logic [`MESH_COORD_W-1:0] row;
    logic [`MESH_COORD_W-1:0] column;
    mesh_cmd_t                command;
} msg_header_t;

// Full message
// READ carries the return node in data[7:0]
typedef struct packed {
    msg_header_t             header;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
} node_message_t;

// Value doubles as stream index, clockwise order
typedef enum logic [1:0] {
    DIRECTION_NORTH = 2'd0,
    DIRECTION_EAST  = 2'd1,
    DIRECTION_SOUTH = 2'd2,
    DIRECTION_WEST  = 2'd3
} direction_t;

// Arbiter selection schemes
typedef enum logic {
    ARB_ROUND_ROBIN = 1'b0,
    ARB_ORDINAL     = 1'b1
} arb_scheme_t;

endpackage : mesh_pkg

`default_nettype wire

//--- design/mesh_stream_arbiter.sv
// mesh_stream_arbiter: registered N-to-1 stream arbiter, round-robin or ordinal
`timescale 1ns/1ps
`default_nettype none

module mesh_stream_arbiter #(
      parameter int                    STREAMS = 4
    , parameter mesh_pkg::arb_scheme_t SCHEME  = mesh_pkg::ARB_ROUND_ROBIN
) (
      input  wire logic                                  i_clk
    , input  wire logic                                  i_rst
    // Inbound streams
    , input  wire mesh_pkg::node_message_t [STREAMS-1:0] i_inbound_data
    , input  wire logic [STREAMS-1:0]                    i_inbound_valid
    , output logic [STREAMS-1:0]                         o_inbound_ready
    // Outbound stream
    , output mesh_pkg::node_message_t                    o_outbound_data
    , output logic                                       o_outbound_valid
    , input  wire logic                                  i_outbound_ready
);

import mesh_pkg::*;

localparam int IDX_W = (STREAMS > 1) ? $clog2(STREAMS) : 1;

// Output register and last grant
node_message_t    data_q;
logic             valid_q;
logic [IDX_W-1:0] last_q;

// Selection
logic [IDX_W-1:0] pick;
logic             pick_found;
logic             load;

// Empty or draining this cycle
assign load = !valid_q || i_outbound_ready;

assign o_outbound_data  = data_q;
assign o_outbound_valid = valid_q;

always_comb begin : comb_pick
    int idx;
    pick       = '0;
    pick_found = 1'b0;
    idx        = 0;
    // Walk backwards, so the highest-priority candidate is written last
    for (int k = STREAMS; k >= 1; k--) begin
        if (SCHEME == ARB_ORDINAL) begin
            idx = k - 1;
        end else begin
            idx = (int'(last_q) + k) % STREAMS;
        end
        if (i_inbound_valid[idx]) begin
            pick       = IDX_W'(idx);
            pick_found = 1'b1;
        end
    end
end

// Only the winner sees ready while valid
always_comb begin : comb_ready
    for (int i = 0; i < STREAMS; i++) begin
        o_inbound_ready[i] = load &&
            (!i_inbound_valid[i] || (pick_found && (pick == IDX_W'(i))));
    end
end

always_ff @(posedge i_clk) begin : ff_ctrl
    if (i_rst) begin
        valid_q <= 1'b0;
        last_q  <= '0;
    end else if (load) begin
        valid_q <= pick_found;
        if (pick_found) begin
            last_q <= pick;
        end
    end
end

// Payload capture
always_ff @(posedge i_clk) begin : ff_data
    if (load && pick_found) begin
        data_q <= i_inbound_data[pick];
    end
end

endmodule : mesh_stream_arbiter

`default_nettype wire

//--- design/mesh_stream_distributor.sv
// mesh_stream_distributor: registered 1-to-4 stream steering with idle flag
`timescale 1ns/1ps
`default_nettype none

module mesh_stream_distributor (
      input  wire logic                           i_clk
    , input  wire logic                           i_rst
    // Idle flag
    , output logic                                o_idle
    // Inbound stream with its direction
    , input  wire mesh_pkg::direction_t           i_inbound_dir
    , input  wire mesh_pkg::node_message_t        i_inbound_data
    , input  wire logic                           i_inbound_valid
    , output logic                                o_inbound_ready
    // Outbound streams, one per direction
    , output mesh_pkg::node_message_t [3:0]       o_outbound_data
    , output logic [3:0]                          o_outbound_valid
    , input  wire logic [3:0]                     i_outbound_ready
);

import mesh_pkg::*;

// Holding register
node_message_t data_q;
direction_t    dir_q;
logic          valid_q;

assign o_idle = !valid_q;

// Free, or the selected port takes it now
assign o_inbound_ready = !valid_q || i_outbound_ready[dir_q];

// Data fans out, valid only on the chosen port
always_comb begin : comb_outbound
    for (int d = 0; d < 4; d++) begin
        o_outbound_data[d]  = data_q;
        o_outbound_valid[d] = valid_q && (int'(dir_q) == d);
    end
end

always_ff @(posedge i_clk) begin : ff_ctrl
    if (i_rst) begin
        valid_q <= 1'b0;
    end else if (o_inbound_ready) begin
        valid_q <= i_inbound_valid;
    end
end

// Message and direction travel together
always_ff @(posedge i_clk) begin : ff_data
    if (o_inbound_ready && i_inbound_valid) begin
        data_q <= i_inbound_data;
        dir_q  <= i_inbound_dir;
    end
end

endmodule : mesh_stream_distributor

`default_nettype wire

//--- tb.f
+incdir+design
design/mesh_pkg.sv
design/mesh_stream_arbiter.sv
design/mesh_stream_distributor.sv
design/mesh_node_decoder.sv
design/mesh_node_store.sv
design/mesh_node_responder.sv
design/mesh_node.sv
tests/tb_mesh_node.sv

//--- tests/tb_mesh_node.sv
// Mesh node testbench with clock, reset, stream drivers, reference models, scoreboard and tests
`timescale 1ns/1ps
`default_nettype none

`include "mesh_defines.svh"

module tb_mesh_node;

import mesh_pkg::*;

localparam int       TIMEOUT = 1000;
localparam node_id_t OWN_ID  = '{row: 4'd5, column: 4'd5};

// ========================================
// DUT signals
// ========================================

logic                        clk;
logic                        rst;
node_id_t                    node_id;
logic                        idle_in;
logic                        o_idle;
logic [3:0][`MESH_MSG_W-1:0] in_data;
logic [3:0]                  in_valid;
logic [3:0]                  o_inbound_ready;
logic [3:0][`MESH_MSG_W-1:0] o_outbound_data;
logic [3:0]                  o_outbound_valid;
logic [3:0]                  out_ready;
logic [3:0]                  out_present;

// Scoreboard state
node_message_t           exp_q [4][$];
logic [`MESH_DATA_W-1:0] model [2**`MESH_ADDR_W];
logic                    bp_enable;
int                      errors;
int                      checks;
int                      received;

mesh_node i_mesh_node (
      .i_clk              ( clk              )
    , .i_rst              ( rst              )
    , .i_node_id          ( node_id          )
    , .i_idle             ( idle_in          )
    , .o_idle             ( o_idle           )
    , .i_inbound_data     ( in_data          )
    , .i_inbound_valid    ( in_valid         )
    , .o_inbound_ready    ( o_inbound_ready  )
    , .o_outbound_data    ( o_outbound_data  )
    , .o_outbound_valid   ( o_outbound_valid )
    , .i_outbound_ready   ( out_ready        )
    , .i_outbound_present ( out_present      )
);

initial begin : clock_gen
    clk = 1'b0;
    forever begin
        #2 clk = ~clk;
    end
end

// ========================================
// Reference model and checks
// ========================================

// Row first and then column, with the clockwise neighbour when absent
function automatic direction_t route_dir(input node_id_t tgt, input logic [3:0] present);
    if (tgt.row < OWN_ID.row) begin
        return present[DIRECTION_NORTH] ? DIRECTION_NORTH : DIRECTION_EAST;
    end
    if (tgt.row > OWN_ID.row) begin
        return present[DIRECTION_SOUTH] ? DIRECTION_SOUTH : DIRECTION_WEST;
    end
    if (tgt.column < OWN_ID.column) begin
        return present[DIRECTION_WEST] ? DIRECTION_WEST : DIRECTION_NORTH;
    end
    return present[DIRECTION_EAST] ? DIRECTION_EAST : DIRECTION_SOUTH;
endfunction

// Any node except this one
function automatic node_id_t other_node();
    node_id_t t;
    t = node_id_t'(8'($urandom));
    if (t == OWN_ID) begin
        t.column = t.column + 4'd1;
    end
    return t;
endfunction

function automatic node_message_t bypass_message();
    node_message_t m;
    node_id_t      t;
    m               = node_message_t'($urandom);
    t               = other_node();
    m.header.row    = t.row;
    m.header.column = t.column;
    return m;
endfunction

// Messages still expected on any outbound port
function automatic int pending_count();
    return exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size();
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
        errors++;
    end
endtask

// Accepted inbound messages become expected outbound ones
always @(negedge clk) begin : inbound_monitor
    node_message_t m;
    node_message_t r;
    node_id_t      ret;
    if (!rst) begin
        for (int s = 0; s < 4; s++) begin
            if (in_valid[s] && o_inbound_ready[s]) begin
                m = in_data[s];
                if (m.header.row == OWN_ID.row && m.header.column == OWN_ID.column) begin
                    if (m.header.command == MESH_CMD_LOAD) begin
                        model[m.addr] = m.data;
                    end else if (m.header.command == MESH_CMD_READ) begin
                        // Response heads back to the return node
                        ret              = node_id_t'(m.data[7:0]);
                        r.header.row     = ret.row;
                        r.header.column  = ret.column;
                        r.header.command = MESH_CMD_RESPONSE;
                        r.addr           = m.addr;
                        r.data           = model[m.addr];
                        exp_q[route_dir(ret, out_present)].push_back(r);
                    end
                end else begin
                    ret = '{row: m.header.row, column: m.header.column};
                    exp_q[route_dir(ret, out_present)].push_back(m);
                end
            end
        end
    end
end

// Compares every outbound transfer with the head of its queue
always @(negedge clk) begin : scoreboard
    node_message_t exp;
    if (!rst) begin
        for (int d = 0; d < 4; d++) begin
            if (o_outbound_valid[d] && out_ready[d]) begin
                received++;
                if (exp_q[d].size() == 0) begin
                    $display("Unexpected message 0x%08h left on outbound port %0d",
                             o_outbound_data[d], d);
                    errors++;
                end else begin
                    exp = exp_q[d].pop_front();
                    check_value($sformatf("o_outbound_data[%0d]", d), o_outbound_data[d], exp);
                end
            end
        end
    end
end

// Random downstream stalls when enabled
always @(posedge clk) begin : backpressure
    #1;
    out_ready = bp_enable ? 4'($urandom) : 4'hF;
end

// ========================================
// Stimulus tasks
// ========================================

// Called 1 ns after a rising edge and returns at the same point
task automatic drive_message(input int src, input node_message_t m);
    int cycles;
    cycles        = 0;
    in_data[src]  = m;
    in_valid[src] = 1'b1;
    @(negedge clk);
    while (!o_inbound_ready[src]) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Inbound stream %0d was never accepted", src);
            errors++;
            break;
        end
        @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid[src] = 1'b0;
endtask

// A message in flight must pull o_idle low
task automatic expect_busy(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (o_idle) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("o_idle stayed high while %s was in flight", what);
            errors++;
            break;
        end
        @(negedge clk);
    end
    @(posedge clk);
    #1;
endtask

task automatic wait_drain(input string what);
    int cycles;
    cycles = 0;
    // Let the last accepted message reach the pipeline first
    repeat (2) @(negedge clk);
    while (pending_count() != 0 || !o_idle) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            if (pending_count() != 0) begin
                $display("Messages still missing on the outbound ports after %s", what);
            end else begin
                $display("o_idle stayed low after %s had drained", what);
            end
            errors++;
            break;
        end
        @(negedge clk);
    end
    @(posedge clk);
    #1;
endtask

task automatic route_bypass(input int count);
    for (int i = 0; i < count; i++) begin
        drive_message(int'($urandom_range(3, 0)), bypass_message());
    end
    wait_drain("bypass traffic");
endtask

task automatic vary_neighbours(input int rounds);
    for (int r = 0; r < rounds; r++) begin
        out_present = 4'($urandom);
        route_bypass(8);
    end
    out_present = 4'hF;
endtask

task automatic load_and_read(input int pairs);
    node_message_t           m;
    node_id_t                ret;
    logic [`MESH_ADDR_W-1:0] addrs [$];
    for (int i = 0; i < pairs; i++) begin
        m                = node_message_t'($urandom);
        m.header.row     = OWN_ID.row;
        m.header.column  = OWN_ID.column;
        m.header.command = MESH_CMD_LOAD;
        addrs.push_back(m.addr);
        drive_message(int'($urandom_range(3, 0)), m);
    end
    // Nothing may leave for the LOADs
    wait_drain("LOAD messages");
    for (int i = 0; i < pairs; i++) begin
        m                = node_message_t'($urandom);
        m.header.row     = OWN_ID.row;
        m.header.column  = OWN_ID.column;
        m.header.command = MESH_CMD_READ;
        m.addr           = addrs[$urandom_range(addrs.size() - 1, 0)];
        ret              = other_node();
        m.data[7:0]      = ret;
        drive_message(int'($urandom_range(3, 0)), m);
    end
    wait_drain("READ messages");
endtask

task automatic burst_on_stream(input int src, input int count);
    for (int i = 0; i < count; i++) begin
        drive_message(src, bypass_message());
    end
endtask

task automatic flood_streams(input int count);
    fork
        burst_on_stream(0, count);
        burst_on_stream(1, count);
        burst_on_stream(2, count);
        burst_on_stream(3, count);
    join
    wait_drain("concurrent traffic");
endtask

task automatic report_test(input string name, input int errs_at_start);
    $display("Test %s: %s", name, (errors == errs_at_start) ? "ok" : "errors found");
endtask

// ========================================
// Test sequence
// ========================================

initial begin : main
    int errs;
    void'($urandom(55731));
    errors      = 0;
    checks      = 0;
    received    = 0;
    bp_enable   = 1'b0;
    rst         = 1'b1;
    node_id     = OWN_ID;
    idle_in     = 1'b1;
    in_data     = '0;
    in_valid    = '0;
    out_ready   = 4'hF;
    out_present = 4'hF;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset state and idle chain
    errs = errors;
    @(negedge clk);
    check_value("o_outbound_valid", 32'(o_outbound_valid), 32'h0);
    check_value("o_inbound_ready", 32'(o_inbound_ready), 32'hF);
    check_value("o_idle", 32'(o_idle), 32'h1);
    @(posedge clk);
    #1;
    idle_in = 1'b0;
    @(negedge clk);
    check_value("o_idle", 32'(o_idle), 32'h0);
    @(posedge clk);
    #1;
    idle_in = 1'b1;
    report_test("1 reset and idle", errs);

    errs = errors;
    drive_message(0, bypass_message());
    expect_busy("a bypass message");
    route_bypass(24);
    report_test("2 bypass routing", errs);

    errs = errors;
    vary_neighbours(4);
    report_test("3 absent neighbours", errs);

    errs = errors;
    load_and_read(8);
    report_test("4 load and read", errs);

    errs = errors;
    flood_streams(12);
    report_test("5 concurrent streams", errs);

    // Same traffic under random stalls
    errs      = errors;
    bp_enable = 1'b1;
    route_bypass(16);
    vary_neighbours(3);
    load_and_read(6);
    flood_streams(10);
    bp_enable = 1'b0;
    report_test("6 back-pressure", errs);

    $display("Summary: %0d checks, %0d messages received, %0d errors", checks, received, errors);
    if (errors == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

endmodule : tb_mesh_node

`default_nettype wire
